// ==== include/pager_cfg.svh ====
// memory pager configuration
`ifndef PAGER_CFG_SVH
`define PAGER_CFG_SVH

// page number width; page plus 14-bit offset makes the 4 MB address
`define PAGER_PAGE_W 8

// physical memory address width
`define PAGER_ADDR_W 22

// number of 16 KB cpu windows
`define PAGER_WIN_N 4

// low address byte of the ATM xxF7 port family
`define PAGER_PORT_LO 8'hF7

// za[13:8] of an M1 fetch that enters DOS
`define PAGER_DOS_PAGE 6'h3D

// extra fclk cycles of z80 clock stall after the DOS entry cycle
`define PAGER_STALL_CYC 3

`endif

// ==== source/pager_pkg.sv ====
// memory pager types
package pager_pkg;

	// cpu window index, same as za[15:14]
	typedef logic [1:0] win_idx_t;

	// xxF7 port data byte, decoded by za[11] of the port address
	typedef union packed
	{
		// xFF7 ports, 1 MB style page with 7FFD merge control
		struct packed
		{
			logic       dos_7ffd; // 7ffd bits merge (ram) or DOS rom switching (rom)
			logic       ramnrom;  // 1 = ram, 0 = rom
			logic [5:0] page_n;   // inverted page number
		} mega;

		// x7F7 ports, full 4 MB ram page
		struct packed
		{
			logic [7:0] page_n;   // inverted page number
		} full;
	} atm_port_data_u;

endpackage

// ==== source/zbus_sync.sv ====
// z80 bus strobe sampler
`timescale 1ns/10ps
`include "pager_cfg.svh"

module zbus_sync
(
	input  logic       fclk,
	input  logic       rst,
	input  logic       zpos,      // fclk phase strobe, z80 clock rising
	input  logic       zneg,      // fclk phase strobe, z80 clock falling
	input  logic       m1_n,
	input  logic       mreq_n,
	input  logic       iorq_n,
	input  logic       wr_n,
	input  logic [7:0] za_lo,     // low byte of the z80 address
	output logic       atm_f7_wr, // xxF7 port write, one fclk
	output logic       fetch_stb  // start of an M1 memory cycle, one fclk
);

	logic m1_n_reg;   // m1_n as seen on the last zpos
	logic mreq_n_reg; // mreq_n as seen on the last zneg
	logic iorq_n_reg; // iorq_n as seen on the last zneg

	// m1 goes low ahead of mreq, so zpos is early enough for it
	always_ff @(posedge fclk)
	begin
		if (rst)
			m1_n_reg <= 1'b1;
		else if (zpos)
			m1_n_reg <= m1_n;
	end

	always_ff @(posedge fclk)
	begin
		if (rst)
		begin
			mreq_n_reg <= 1'b1;
			iorq_n_reg <= 1'b1;
		end
		else if (zneg)
		begin
			mreq_n_reg <= mreq_n;
			iorq_n_reg <= iorq_n;
		end
	end

	// io write just started on this zneg, decoded once for all windows
	assign atm_f7_wr = zneg && !iorq_n && !wr_n && iorq_n_reg &&
		(za_lo == `PAGER_PORT_LO);

	// falling mreq during an opcode fetch
	assign fetch_stb = zneg && !m1_n_reg && !mreq_n && mreq_n_reg;

	// z80 clock cannot rise and fall in the same fclk
	a_phase_excl: assert property (@(posedge fclk) disable iff (rst)
		!(zpos && zneg));

endmodule

// ==== source/atm_pager.sv ====
// ATM window pager
`timescale 1ns/10ps
`include "pager_cfg.svh"

module atm_pager
	import pager_pkg::*;
#(
	parameter win_idx_t WIN = 2'd0 // window this pager owns
)
(
	input  logic                     fclk,
	input  logic                     rst,
	input  logic [15:0]              za,
	input  logic [7:0]               zd,
	input  logic                     atm_f7_wr,
	input  logic                     fetch_stb,
	input  logic                     pager_off,     // service rom everywhere
	input  logic                     pent1m_rom,    // 7ffd rom bit, picks the map
	input  logic                     pent1m_ram0_0, // ram page 0 in window 0
	input  logic                     pent1m_1m_on,  // 1 MB 7ffd addressing
	input  logic                     in_nmi,        // last ram page in window 0
	input  logic                     dos,
	input  logic [5:0]               pent1m_page,   // page bits from 7ffd
	output logic [`PAGER_PAGE_W-1:0] page,
	output logic                     romnram,       // 1 = rom, 0 = ram
	output logic                     turn_on,       // DOS entry fetch in this window
	output logic                     turn_off       // ram fetch in this window
);

	logic [`PAGER_PAGE_W-1:0] pages [2]; // one per map, indexed by pent1m_rom
	logic [1:0]               ramnrom;   // 1 = ram map
	logic [1:0]               dos_7ffd;  // 7ffd merge or DOS rom switching
	atm_port_data_u           pd;        // port byte in both views
	logic                     win_hit;   // za points into this window
	logic                     map_sel;

	assign pd      = zd;
	assign win_hit = (za[15:14] == WIN);
	assign map_sel = pent1m_rom;

	// port writes land in the map currently selected by 7ffd
	always_ff @(posedge fclk)
	begin
		if (rst)
		begin
			pages[0] <= '0;
			pages[1] <= '0;
			ramnrom  <= 2'b00;
			dos_7ffd <= 2'b00;
		end
		else if (atm_f7_wr && win_hit)
		begin
			if (za[11]) // xFF7
			begin
				pages[map_sel]    <= {2'b00, ~pd.mega.page_n};
				ramnrom[map_sel]  <= pd.mega.ramnrom;
				dos_7ffd[map_sel] <= pd.mega.dos_7ffd;
			end
			else // x7F7, dos_7ffd kept so 7ffd merging works over all 4 MB
			begin
				pages[map_sel]   <= ~pd.full.page_n;
				ramnrom[map_sel] <= 1'b1;
			end
		end
	end

	// paging function, highest priority first
	always_ff @(posedge fclk)
	begin
		if (rst || pager_off)
		begin
			page    <= '1; // service rom
			romnram <= 1'b1;
		end
		else if ((WIN == 2'd0) && in_nmi)
		begin
			page    <= '1; // last ram page for the nmi handler
			romnram <= 1'b0;
		end
		else if ((WIN == 2'd0) && pent1m_ram0_0)
		begin
			page    <= '0;
			romnram <= 1'b0;
		end
		else
		begin
			romnram <= ~ramnrom[map_sel];
			if (!dos_7ffd[map_sel])
				page <= pages[map_sel]; // plain atm page
			else if (ramnrom[map_sel] && pent1m_1m_on)
				page <= {pages[map_sel][7:6], pent1m_page}; // whole 1 MB from 7ffd
			else if (ramnrom[map_sel])
				page <= {pages[map_sel][7:3], pent1m_page[2:0]}; // 128 KB like atm2
			else
				page <= {pages[map_sel][7:1], dos}; // rom pair, dos picks the half
		end
	end

	// entry needs map 1 to be a DOS-switching rom and 7ffd pointing at it
	assign turn_on = fetch_stb && win_hit && (za[13:8] == `PAGER_DOS_PAGE) &&
		dos_7ffd[1] && !ramnrom[1] && pent1m_rom;

	// any opcode from ram outside window 0 leaves DOS
	assign turn_off = fetch_stb && win_hit && (WIN != 2'd0) && ramnrom[map_sel];

	// io and memory cycles never overlap, so a fetch never sees a half-done write
	a_wr_fetch_excl: assert property (@(posedge fclk) disable iff (rst)
		!(atm_f7_wr && fetch_stb));

endmodule

// ==== source/dos_ctrl.sv ====
// DOS state and clock stall
`timescale 1ns/10ps
`include "pager_cfg.svh"

module dos_ctrl
(
	input  logic                    fclk,
	input  logic                    rst,
	input  logic [`PAGER_WIN_N-1:0] turn_on,  // per window DOS entry
	input  logic [`PAGER_WIN_N-1:0] turn_off, // per window DOS exit
	output logic                    dos,
	output logic                    zclk_stall // hold z80 clock while rom settles
);

	localparam int CNT_W     = $clog2(`PAGER_STALL_CYC + 1);
	localparam int STALL_LEN = `PAGER_STALL_CYC + 1; // entry cycle plus the tail

	logic             any_on;
	logic             any_off;
	logic [CNT_W-1:0] stall_cnt; // cycles of stall left after this one

	assign any_on  = |turn_on;
	assign any_off = |turn_off;

	// entry wins if both show up in one cycle
	always_ff @(posedge fclk)
	begin
		if (rst)
			dos <= 1'b0;
		else if (any_on)
			dos <= 1'b1;
		else if (any_off)
			dos <= 1'b0;
	end

	// rom output needs a few fclk to follow the DOS switch
	always_ff @(posedge fclk)
	begin
		if (rst)
			stall_cnt <= '0;
		else if (any_on)
			stall_cnt <= CNT_W'(`PAGER_STALL_CYC);
		else if (stall_cnt != '0)
			stall_cnt <= stall_cnt - 1'b1;
	end

	assign zclk_stall = any_on || (stall_cnt != '0); // rises in the entry cycle

	a_stall_len: assert property (@(posedge fclk) disable iff (rst)
		zclk_stall [*STALL_LEN] |=> !zclk_stall);

endmodule

// ==== source/mem_addr_mux.sv ====
// memory address mux
`timescale 1ns/10ps
`include "pager_cfg.svh"

module mem_addr_mux
	import pager_pkg::*;
(
	input  logic [15:0]                                za,
	input  logic [`PAGER_WIN_N-1:0][`PAGER_PAGE_W-1:0] pages,    // registered window pages
	input  logic [`PAGER_WIN_N-1:0]                    romnrams,
	output logic [`PAGER_ADDR_W-1:0]                   mem_addr,
	output logic                                       mem_romnram // 1 = rom chip
);

	localparam int OFS_W = `PAGER_ADDR_W - `PAGER_PAGE_W; // 16 KB offset

	win_idx_t win; // window of the current cpu address

	assign win = za[15:14];

	// page on top, in-window offset below
	assign mem_addr    = {pages[win], za[OFS_W-1:0]};
	assign mem_romnram = romnrams[win];

endmodule

// ==== source/mem_pager_top.sv ====
// memory pager top
`timescale 1ns/10ps
`include "pager_cfg.svh"

module mem_pager_top
	import pager_pkg::*;
(
	input  logic                     fclk,
	input  logic                     rst,
	input  logic                     zpos,
	input  logic                     zneg,
	input  logic [15:0]              za,
	input  logic [7:0]               zd,
	input  logic                     m1_n,
	input  logic                     mreq_n,
	input  logic                     iorq_n,
	input  logic                     wr_n,
	input  logic                     pager_off,
	input  logic                     pent1m_rom,
	input  logic [5:0]               pent1m_page,
	input  logic                     pent1m_ram0_0,
	input  logic                     pent1m_1m_on,
	input  logic                     in_nmi,
	output logic [`PAGER_ADDR_W-1:0] mem_addr,
	output logic                     mem_romnram,
	output logic                     dos,
	output logic                     zclk_stall
);

	logic                                       atm_f7_wr;
	logic                                       fetch_stb;
	logic [`PAGER_WIN_N-1:0][`PAGER_PAGE_W-1:0] pages;
	logic [`PAGER_WIN_N-1:0]                    romnrams;
	logic [`PAGER_WIN_N-1:0]                    turn_on;
	logic [`PAGER_WIN_N-1:0]                    turn_off;

	zbus_sync zbus_sync_i
	(
		.fclk      (fclk),
		.rst       (rst),
		.zpos      (zpos),
		.zneg      (zneg),
		.m1_n      (m1_n),
		.mreq_n    (mreq_n),
		.iorq_n    (iorq_n),
		.wr_n      (wr_n),
		.za_lo     (za[7:0]),
		.atm_f7_wr (atm_f7_wr),
		.fetch_stb (fetch_stb)
	);

	// one pager per 16 KB window
	for (genvar i = 0; i < `PAGER_WIN_N; i++)
	begin : g_win
		atm_pager #(.WIN(win_idx_t'(i))) atm_pager_i
		(
			.fclk          (fclk),
			.rst           (rst),
			.za            (za),
			.zd            (zd),
			.atm_f7_wr     (atm_f7_wr),
			.fetch_stb     (fetch_stb),
			.pager_off     (pager_off),
			.pent1m_rom    (pent1m_rom),
			.pent1m_ram0_0 (pent1m_ram0_0),
			.pent1m_1m_on  (pent1m_1m_on),
			.in_nmi        (in_nmi),
			.dos           (dos),
			.pent1m_page   (pent1m_page),
			.page          (pages[i]),
			.romnram       (romnrams[i]),
			.turn_on       (turn_on[i]),
			.turn_off      (turn_off[i])
		);
	end

	dos_ctrl dos_ctrl_i
	(
		.fclk       (fclk),
		.rst        (rst),
		.turn_on    (turn_on),
		.turn_off   (turn_off),
		.dos        (dos),
		.zclk_stall (zclk_stall)
	);

	mem_addr_mux mem_addr_mux_i
	(
		.za          (za),
		.pages       (pages),
		.romnrams    (romnrams),
		.mem_addr    (mem_addr),
		.mem_romnram (mem_romnram)
	);

endmodule

// ==== test/tb_mem_pager.sv ====
// memory pager testbench
`timescale 1ns/10ps
`include "pager_cfg.svh"

module tb_mem_pager
	import pager_pkg::*;
();

	localparam int RESET_CYC  = 8;
	localparam int SETTLE_CYC = 3;    // port write to mem_addr is 2 cycles, plus one spare
	localparam int STALL_LEN  = `PAGER_STALL_CYC + 1;
	localparam int MAX_CYC    = 3000; // all tests take roughly 500 cycles

	logic                     fclk;
	logic                     rst;
	logic                     zpos;
	logic                     zneg;
	logic [15:0]              za;
	logic [7:0]               zd;
	logic                     m1_n;
	logic                     mreq_n;
	logic                     iorq_n;
	logic                     wr_n;
	logic                     pager_off;
	logic                     pent1m_rom;
	logic [5:0]               pent1m_page;
	logic                     pent1m_ram0_0;
	logic                     pent1m_1m_on;
	logic                     in_nmi;
	logic [`PAGER_ADDR_W-1:0] mem_addr;
	logic                     mem_romnram;
	logic                     dos;
	logic                     zclk_stall;

	// reference model of the page registers, [map][window]
	logic [7:0] m_page [2][4];
	logic       m_ram  [2][4];
	logic       m_dos7 [2][4];
	logic       exp_dos;

	int   cyc = 0;     // fclk cycles since start
	int   last_change; // cycle of the last stimulus change
	int   err_cnt;
	int   err_mark;    // err_cnt when the current test began
	int   test_no;
	logic settled;     // outputs have caught up with the model

	mem_pager_top mem_pager_top_i
	(
		.fclk          (fclk),
		.rst           (rst),
		.zpos          (zpos),
		.zneg          (zneg),
		.za            (za),
		.zd            (zd),
		.m1_n          (m1_n),
		.mreq_n        (mreq_n),
		.iorq_n        (iorq_n),
		.wr_n          (wr_n),
		.pager_off     (pager_off),
		.pent1m_rom    (pent1m_rom),
		.pent1m_page   (pent1m_page),
		.pent1m_ram0_0 (pent1m_ram0_0),
		.pent1m_1m_on  (pent1m_1m_on),
		.in_nmi        (in_nmi),
		.mem_addr      (mem_addr),
		.mem_romnram   (mem_romnram),
		.dos           (dos),
		.zclk_stall    (zclk_stall)
	);

	initial
	begin
		fclk = 1'b0;
		forever #2 fclk = ~fclk; // 4 ns period
	end

	// z80 clock at half fclk, zpos and zneg on alternate cycles
	initial
	begin
		zpos = 1'b0;
		zneg = 1'b0;
		forever
		begin
			@(negedge fclk);
			zneg = zpos;
			zpos = ~zpos;
		end
	end

	always @(posedge fclk)
	begin
		cyc <= cyc + 1;
		if (cyc >= MAX_CYC)
		begin
			$display("timeout: run still going after %0d cycles", MAX_CYC);
			$display("Errors found");
			$finish;
		end
	end

	assign settled = (cyc - last_change) >= SETTLE_CYC;

	task automatic report_check(input string msg);
		$display("CHECK FAILED at %0t ns: %s", $time, msg);
		err_cnt++;
	endtask

	// {romnram, page} of window w as the priority rules give it
	function automatic logic [8:0] expect_map(input logic [1:0] w);
		logic       m;
		logic [7:0] p;
		m = pent1m_rom;
		p = m_page[m][w];
		if (pager_off)
			return {1'b1, 8'hFF};
		if ((w == 2'd0) && in_nmi)
			return {1'b0, 8'hFF};
		if ((w == 2'd0) && pent1m_ram0_0)
			return {1'b0, 8'h00};
		if (m_dos7[m][w])
		begin
			if (m_ram[m][w] && pent1m_1m_on)
				p = {p[7:6], pent1m_page};
			else if (m_ram[m][w])
				p = {p[7:3], pent1m_page[2:0]};
			else
				p = {p[7:1], exp_dos}; // dos picks the rom half
		end
		return {~m_ram[m][w], p};
	endfunction

	function automatic logic [`PAGER_ADDR_W-1:0] expect_addr(input logic [15:0] a);
		logic [8:0] r;
		r = expect_map(a[15:14]);
		return {r[7:0], a[13:0]};
	endfunction

	function automatic logic expect_rom(input logic [15:0] a);
		logic [8:0] r;
		r = expect_map(a[15:14]);
		return r[8];
	endfunction

	function automatic logic [7:0] mega_byte(input logic dos7, input logic ram,
		input logic [5:0] pg);
		atm_port_data_u d;
		d.mega.dos_7ffd = dos7;
		d.mega.ramnrom  = ram;
		d.mega.page_n   = ~pg; // port carries the page inverted
		return d;
	endfunction

	// model side of an io write, only xxF7 ports count
	task automatic model_port(input logic [15:0] a, input logic [7:0] data);
		atm_port_data_u d;
		logic           m;
		logic [1:0]     w;
		d = data;
		m = pent1m_rom;
		w = a[15:14];
		if (a[7:0] == `PAGER_PORT_LO)
		begin
			if (a[11]) // xFF7
			begin
				m_page[m][w] = {2'b00, ~d.mega.page_n};
				m_ram[m][w]  = d.mega.ramnrom;
				m_dos7[m][w] = d.mega.dos_7ffd;
			end
			else // x7F7
			begin
				m_page[m][w] = ~d.full.page_n;
				m_ram[m][w]  = 1'b1;
			end
		end
	endtask

	task automatic model_fetch(input logic [15:0] a);
		logic [1:0] w;
		logic       on;
		logic       off;
		w   = a[15:14];
		on  = (a[13:8] == `PAGER_DOS_PAGE) && m_dos7[1][w] && !m_ram[1][w] && pent1m_rom;
		off = (w != 2'd0) && m_ram[pent1m_rom][w];
		if (on)
			exp_dos = 1'b1; // entry wins
		else if (off)
			exp_dos = 1'b0;
	endtask

	task automatic idle(input int n);
		repeat (n) @(negedge fclk);
	endtask

	task automatic port_write(input logic [15:0] a, input logic [7:0] data);
		@(negedge fclk);
		za          = a;
		zd          = data;
		iorq_n      = 1'b0;
		wr_n        = 1'b0;
		last_change = cyc;
		model_port(a, data);
		idle(4); // spans two zneg, only the first one writes
		iorq_n      = 1'b1;
		wr_n        = 1'b1;
		last_change = cyc;
		idle(4);
	endtask

	task automatic fetch(input logic [15:0] a);
		@(negedge fclk);
		za          = a;
		m1_n        = 1'b0; // m1 ahead of mreq, seen on a zpos first
		last_change = cyc;
		idle(2);
		mreq_n      = 1'b0;
		last_change = cyc;
		model_fetch(a);
		idle(4);
		m1_n        = 1'b1;
		mreq_n      = 1'b1;
		last_change = cyc;
		idle(4);
	endtask

	task automatic set_modes(input logic off, input logic rom, input logic ram0,
		input logic nmi, input logic m1on, input logic [5:0] pg);
		@(negedge fclk);
		pager_off     = off;
		pent1m_rom    = rom;
		pent1m_ram0_0 = ram0;
		in_nmi        = nmi;
		pent1m_1m_on  = m1on;
		pent1m_page   = pg;
		last_change   = cyc;
		idle(5);
	endtask

	// park the cpu address somewhere in window w
	task automatic look(input logic [1:0] w);
		@(negedge fclk);
		za          = {w, 14'($urandom)};
		last_change = cyc;
		idle(5);
	endtask

	task automatic look_all();
		for (int i = 0; i < 4; i++)
			look(2'(i));
	endtask

	task automatic end_test(input string name);
		test_no++;
		if (err_cnt == err_mark)
			$display("test %0d %s: ok", test_no, name);
		else
			$display("test %0d %s: failed, %0d bad checks", test_no, name, err_cnt - err_mark);
		err_mark = err_cnt;
	endtask

	a_addr: assert property (@(posedge fclk) disable iff (rst)
		settled |-> (mem_addr == expect_addr(za)))
		else report_check($sformatf("mem_addr %h, model %h", mem_addr, expect_addr(za)));

	a_romnram: assert property (@(posedge fclk) disable iff (rst)
		settled |-> (mem_romnram == expect_rom(za)))
		else report_check($sformatf("mem_romnram %b, model %b", mem_romnram, expect_rom(za)));

	a_dos: assert property (@(posedge fclk) disable iff (rst)
		settled |-> (dos == exp_dos))
		else report_check($sformatf("dos %b, model %b", dos, exp_dos));

	// stall must come with every DOS entry
	a_stall_on_entry: assert property (@(posedge fclk) disable iff (rst)
		$rose(dos) |-> $past(zclk_stall))
		else report_check("dos rose without zclk_stall");

	a_stall_len: assert property (@(posedge fclk) disable iff (rst)
		$rose(zclk_stall) |-> zclk_stall [*STALL_LEN] ##1 !zclk_stall)
		else report_check("zclk_stall pulse length is not 4 cycles");

	// a stall started by the last change has run out after STALL_LEN quiet cycles
	a_stall_idle: assert property (@(posedge fclk) disable iff (rst)
		((cyc - last_change) >= STALL_LEN) |-> !zclk_stall)
		else report_check("zclk_stall high outside a DOS entry");

	initial
	begin
		void'($urandom(99141));
		rst           = 1'b1;
		za            = 16'h0000;
		zd            = 8'h00;
		m1_n          = 1'b1;
		mreq_n        = 1'b1;
		iorq_n        = 1'b1;
		wr_n          = 1'b1;
		pager_off     = 1'b0;
		pent1m_rom    = 1'b0;
		pent1m_page   = 6'd0;
		pent1m_ram0_0 = 1'b0;
		pent1m_1m_on  = 1'b0;
		in_nmi        = 1'b0;
		for (int m = 0; m < 2; m++)
			for (int w = 0; w < 4; w++)
			begin
				m_page[m][w] = 8'h00;
				m_ram[m][w]  = 1'b0;
				m_dos7[m][w] = 1'b0;
			end
		exp_dos     = 1'b0;
		err_cnt     = 0;
		err_mark    = 0;
		test_no     = 0;
		last_change = 0;
		idle(RESET_CYC);
		rst         = 1'b0;
		last_change = cyc;
		idle(4);

		set_modes(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 6'd0);
		look_all();
		set_modes(1'b1, 1'b1, 1'b1, 1'b1, 1'b0, 6'd0); // off beats nmi and ram0
		look_all();
		end_test("pager off");

		set_modes(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 6'd0);
		for (int i = 0; i < 4; i++)
			port_write({2'(i), 6'b110111, `PAGER_PORT_LO}, 8'($urandom)); // x7F7
		look_all();
		set_modes(1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 6'd0);
		for (int i = 0; i < 4; i++)
			port_write({2'(i), 6'b110111, `PAGER_PORT_LO}, 8'($urandom));
		look_all();
		set_modes(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 6'd0); // map 0 must be untouched
		look_all();
		end_test("full pages, both maps");

		port_write({2'd1, 6'b111111, `PAGER_PORT_LO}, mega_byte(1'b1, 1'b1, 6'($urandom)));
		set_modes(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 6'($urandom)); // 128 KB merge
		look(2'd1);
		set_modes(1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 6'($urandom)); // 1 MB merge
		look(2'd1);
		port_write({2'd1, 6'b110111, `PAGER_PORT_LO}, 8'($urandom)); // dos_7ffd stays
		look(2'd1);
		port_write({2'd2, 6'b111111, `PAGER_PORT_LO}, mega_byte(1'b1, 1'b0, 6'($urandom)));
		look(2'd2); // rom map, bit 0 from dos
		end_test("7ffd merge");

		set_modes(1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 6'd0);
		look(2'd0);
		look(2'd1);
		set_modes(1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 6'd0); // nmi wins over ram0
		look(2'd0);
		look(2'd3);
		set_modes(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 6'd0);
		end_test("window 0 overrides");

		set_modes(1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 6'($urandom));
		port_write({2'd0, 6'b111111, `PAGER_PORT_LO}, mega_byte(1'b1, 1'b0, 6'($urandom)));
		set_modes(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 6'd0);
		fetch({2'b00, `PAGER_DOS_PAGE, 8'($urandom)}); // 7ffd on map 0, no entry
		set_modes(1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 6'd0);
		fetch({2'b00, `PAGER_DOS_PAGE, 8'($urandom)});
		look(2'd0); // dos now shows in the rom page
		end_test("DOS entry and stall");

		port_write({2'd1, 6'b110111, `PAGER_PORT_LO}, 8'($urandom)); // ram map, window 1
		port_write(16'h7FFD, 8'($urandom));
		port_write({2'd2, 6'b111111, 8'hFE}, 8'($urandom));
		port_write({2'd3, 6'b110111, 8'hF6}, 8'($urandom));
		look_all();
		fetch({2'b01, 14'($urandom)});
		look_all();
		end_test("DOS exit and foreign ports");

		$display("tests run: %0d, failed checks: %0d", test_no, err_cnt);
		if (err_cnt == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

// ==== build.f ====
+incdir+include
source/pager_pkg.sv
source/zbus_sync.sv
source/atm_pager.sv
source/dos_ctrl.sv
source/mem_addr_mux.sv
source/mem_pager_top.sv
test/tb_mem_pager.sv

// ==== Makefile ====
TOP := tb_mem_pager

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -Wno-fatal -f build.f --top-module $(TOP) -o sim_$(TOP)
	@out=$$(./obj_dir/sim_$(TOP)); echo "$$out"; echo "$$out" | grep -qx "No errors"

lint:
	verilator --lint-only -Wall --timing -f build.f --top-module $(TOP)

clean:
	rm -rf obj_dir
